// File: src/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// address of the first fetch after reset
`define CPU_RESET_PC 32'h0000_0000

// data and address width
`define CPU_XLEN 32

// architectural integer registers
`define CPU_NUM_REGS 32

`endif

// File: src/rv32_pkg.sv
`default_nettype none
`include "cpu_params.svh"

package rv32_pkg;

	typedef logic [`CPU_XLEN-1:0] word_t;
	typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;
	typedef logic [3:0] byte_mask_t;

	// alu_add is zero so a bubble computes nothing harmful
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_e;

	typedef enum logic [1:0] {
		cmp_eq,
		cmp_ne,
		cmp_lt,
		cmp_ge
	} cmp_op_e;

	typedef enum logic {
		op_a_rs1,
		op_a_pc
	} op_a_sel_e;

	typedef enum logic {
		op_b_rs2,
		op_b_imm
	} op_b_sel_e;

	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_pc4
	} wb_sel_e;

	typedef enum logic [1:0] {
		jump_none,
		jump_branch,
		jump_jal,
		jump_jalr
	} jump_kind_e;

	// all zero is a bubble
	// unused source fields stay zero so hazard checks skip them
	typedef struct packed {
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		word_t imm;
		alu_op_e alu_op;
		cmp_op_e cmp_op;
		op_a_sel_e op_a_sel;
		op_b_sel_e op_b_sel;
		wb_sel_e wb_sel;
		jump_kind_e jump_kind;
		logic mem_read;
		logic mem_write;
		logic load_regfile;
	} ctrl_word_t;

endpackage

`default_nettype wire

// File: src/mem_port_if.sv
`default_nettype none

interface mem_port_if;

	logic read;
	logic write;
	rv32_pkg::byte_mask_t wmask;
	rv32_pkg::word_t address;
	rv32_pkg::word_t wdata;
	logic resp;
	rv32_pkg::word_t rdata;

	// requester side, drives the request toward memory
	modport memory (
		output read,
		output write,
		output wmask,
		output address,
		output wdata,
		input resp,
		input rdata
	);

	// responder side, answers the core
	modport core (
		input read,
		input write,
		input wmask,
		input address,
		input wdata,
		output resp,
		output rdata
	);

endinterface

`default_nettype wire

// File: src/mem_access_proxy.sv
`default_nettype none

module mem_access_proxy (
	input logic clk,
	input logic arst_n,
	input logic stage_read,
	input logic stage_write,
	input rv32_pkg::word_t stage_addr,
	input rv32_pkg::word_t stage_wdata,
	input rv32_pkg::byte_mask_t stage_wmask,
	input logic pipe_load,
	output logic stage_resp,
	output rv32_pkg::word_t stage_rdata,
	mem_port_if.memory mem
);

	// set once the slot's access has been answered
	logic done_q;
	rv32_pkg::word_t data_q;

	// one request per pipeline slot
	assign mem.read = stage_read & ~done_q;
	assign mem.write = stage_write & ~done_q;
	assign mem.address = stage_addr;
	assign mem.wdata = stage_wdata;
	assign mem.wmask = stage_wmask;

	assign stage_resp = done_q;
	assign stage_rdata = data_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			done_q <= 1'b0;
		end else if (pipe_load) begin
			done_q <= 1'b0;
		end else if (mem.resp) begin
			done_q <= 1'b1;
		end
	end

	// keeps the word across stalls elsewhere in the pipe
	always_ff @(posedge clk) begin
		if (mem.resp) begin
			data_q <= mem.rdata;
		end
	end

	a_resp_needs_request: assert property (
		@(posedge clk) disable iff (!arst_n)
		mem.resp |-> (mem.read || mem.write)
	);

	// the core must hold the pending address until memory answers
	a_request_held: assert property (
		@(posedge clk) disable iff (!arst_n)
		((mem.read || mem.write) && !mem.resp) |=>
			((mem.read || mem.write) && $stable(mem.address))
	);

endmodule

`default_nettype wire

// File: src/control_decoder.sv
`default_nettype none

module control_decoder (
	input rv32_pkg::word_t instr,
	output rv32_pkg::ctrl_word_t ctrl
);

	localparam logic [6:0] opc_lui = 7'b0110111;
	localparam logic [6:0] opc_auipc = 7'b0010111;
	localparam logic [6:0] opc_jal = 7'b1101111;
	localparam logic [6:0] opc_jalr = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_load = 7'b0000011;
	localparam logic [6:0] opc_store = 7'b0100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op = 7'b0110011;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic funct7_alt;
	rv32_pkg::word_t imm_i;
	rv32_pkg::word_t imm_s;
	rv32_pkg::word_t imm_b;
	rv32_pkg::word_t imm_u;
	rv32_pkg::word_t imm_j;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7_alt = instr[30];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// alt picks sub or sra
	function automatic rv32_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? rv32_pkg::alu_sub : rv32_pkg::alu_add;
			3'b001: return rv32_pkg::alu_sll;
			3'b010: return rv32_pkg::alu_slt;
			3'b011: return rv32_pkg::alu_sltu;
			3'b100: return rv32_pkg::alu_xor;
			3'b101: return alt ? rv32_pkg::alu_sra : rv32_pkg::alu_srl;
			3'b110: return rv32_pkg::alu_or;
			default: return rv32_pkg::alu_and;
		endcase
	endfunction

	always_comb begin
		ctrl = '0;
		case (opcode)
			opc_lui: begin
				// x0 plus the upper immediate
				ctrl.rd = instr[11:7];
				ctrl.imm = imm_u;
				ctrl.op_b_sel = rv32_pkg::op_b_imm;
				ctrl.load_regfile = 1'b1;
			end
			opc_auipc: begin
				ctrl.rd = instr[11:7];
				ctrl.imm = imm_u;
				ctrl.op_a_sel = rv32_pkg::op_a_pc;
				ctrl.op_b_sel = rv32_pkg::op_b_imm;
				ctrl.load_regfile = 1'b1;
			end
			opc_jal: begin
				ctrl.rd = instr[11:7];
				ctrl.imm = imm_j;
				ctrl.jump_kind = rv32_pkg::jump_jal;
				ctrl.wb_sel = rv32_pkg::wb_pc4;
				ctrl.load_regfile = 1'b1;
			end
			opc_jalr: begin
				if (funct3 == 3'b000) begin
					ctrl.rs1 = instr[19:15];
					ctrl.rd = instr[11:7];
					ctrl.imm = imm_i;
					ctrl.jump_kind = rv32_pkg::jump_jalr;
					ctrl.wb_sel = rv32_pkg::wb_pc4;
					ctrl.load_regfile = 1'b1;
				end
			end
			opc_branch: begin
				ctrl.rs1 = instr[19:15];
				ctrl.rs2 = instr[24:20];
				ctrl.imm = imm_b;
				ctrl.jump_kind = rv32_pkg::jump_branch;
				case (funct3)
					3'b000: ctrl.cmp_op = rv32_pkg::cmp_eq;
					3'b001: ctrl.cmp_op = rv32_pkg::cmp_ne;
					3'b100: ctrl.cmp_op = rv32_pkg::cmp_lt;
					3'b101: ctrl.cmp_op = rv32_pkg::cmp_ge;
					// unsigned compares are not supported
					default: ctrl = '0;
				endcase
			end
			opc_load: begin
				// word access only
				if (funct3 == 3'b010) begin
					ctrl.rs1 = instr[19:15];
					ctrl.rd = instr[11:7];
					ctrl.imm = imm_i;
					ctrl.op_b_sel = rv32_pkg::op_b_imm;
					ctrl.mem_read = 1'b1;
					ctrl.wb_sel = rv32_pkg::wb_mem;
					ctrl.load_regfile = 1'b1;
				end
			end
			opc_store: begin
				if (funct3 == 3'b010) begin
					ctrl.rs1 = instr[19:15];
					ctrl.rs2 = instr[24:20];
					ctrl.imm = imm_s;
					ctrl.op_b_sel = rv32_pkg::op_b_imm;
					ctrl.mem_write = 1'b1;
				end
			end
			opc_op_imm: begin
				ctrl.rs1 = instr[19:15];
				ctrl.rd = instr[11:7];
				ctrl.imm = imm_i;
				ctrl.op_b_sel = rv32_pkg::op_b_imm;
				// addi has no sub form, only srai uses bit 30
				ctrl.alu_op = alu_from_funct3(funct3, funct7_alt && funct3 == 3'b101);
				ctrl.load_regfile = 1'b1;
			end
			opc_op: begin
				ctrl.rs1 = instr[19:15];
				ctrl.rs2 = instr[24:20];
				ctrl.rd = instr[11:7];
				ctrl.alu_op = alu_from_funct3(funct3, funct7_alt);
				ctrl.load_regfile = 1'b1;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: src/regfile.sv
`default_nettype none
`include "cpu_params.svh"

module regfile (
	input logic clk,
	input logic arst_n,
	input rv32_pkg::reg_idx_t rs1,
	input rv32_pkg::reg_idx_t rs2,
	input rv32_pkg::reg_idx_t rd,
	input rv32_pkg::word_t wdata,
	input logic we,
	output rv32_pkg::word_t rs1_data,
	output rv32_pkg::word_t rs2_data
);

	rv32_pkg::word_t regs [`CPU_NUM_REGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	// x0 reads zero, a same-cycle write is passed straight through
	function automatic rv32_pkg::word_t read_port(input rv32_pkg::reg_idx_t idx);
		if (idx == '0) begin
			return '0;
		end else if (we && rd == idx) begin
			return wdata;
		end
		return regs[idx];
	endfunction

	always_comb begin
		rs1_data = read_port(rs1);
		rs2_data = read_port(rs2);
	end

endmodule

`default_nettype wire

// File: src/hazard_unit.sv
`default_nettype none

module hazard_unit (
	input rv32_pkg::ctrl_word_t ex_ctrl,
	input rv32_pkg::ctrl_word_t mem_ctrl,
	input rv32_pkg::ctrl_word_t wb_ctrl,
	input rv32_pkg::ctrl_word_t id_ctrl,
	input logic instr_resp,
	input logic data_resp,
	input logic redirect,
	output logic [1:0] fwd_sel_a,
	output logic [1:0] fwd_sel_b,
	output logic pc_load,
	output logic id_load,
	output logic ex_load,
	output logic mem_load,
	output logic wb_load,
	output logic id_flush,
	output logic ex_flush
);

	logic load_use;
	logic instr_stall;
	logic data_stall;
	logic hold;
	logic advance_front;

	// 0 register file, 1 memory stage, 2 writeback stage
	function automatic logic [1:0] pick_source(
		input rv32_pkg::reg_idx_t src,
		input rv32_pkg::ctrl_word_t mem_c,
		input rv32_pkg::ctrl_word_t wb_c
	);
		if (src == '0) begin
			return 2'd0;
		end
		// younger result wins
		if (mem_c.load_regfile && mem_c.rd == src) begin
			return 2'd1;
		end
		if (wb_c.load_regfile && wb_c.rd == src) begin
			return 2'd2;
		end
		return 2'd0;
	endfunction

	always_comb begin
		fwd_sel_a = pick_source(ex_ctrl.rs1, mem_ctrl, wb_ctrl);
		fwd_sel_b = pick_source(ex_ctrl.rs2, mem_ctrl, wb_ctrl);
	end

	// load result is only ready in writeback
	assign load_use = ex_ctrl.mem_read && ex_ctrl.rd != '0 &&
		(ex_ctrl.rd == id_ctrl.rs1 || ex_ctrl.rd == id_ctrl.rs2);

	assign instr_stall = ~instr_resp;
	assign data_stall = (mem_ctrl.mem_read | mem_ctrl.mem_write) & ~data_resp;

	// a redirect waits for the outstanding fetch so its address stays put
	assign hold = data_stall | (redirect & instr_stall);
	assign advance_front = ~hold & (redirect | (~instr_stall & ~load_use));

	assign pc_load = advance_front;
	assign id_load = advance_front;
	assign ex_load = ~hold;
	assign mem_load = ~hold;
	assign wb_load = ~hold;

	assign id_flush = redirect;
	assign ex_flush = redirect | load_use | instr_stall;

endmodule

`default_nettype wire

// File: src/execute_unit.sv
`default_nettype none

module execute_unit (
	input rv32_pkg::ctrl_word_t ctrl,
	input rv32_pkg::word_t pc,
	input rv32_pkg::word_t rs1_data,
	input rv32_pkg::word_t rs2_data,
	input rv32_pkg::word_t mem_fwd,
	input rv32_pkg::word_t wb_fwd,
	input logic [1:0] fwd_sel_a,
	input logic [1:0] fwd_sel_b,
	output rv32_pkg::word_t alu_out,
	output rv32_pkg::word_t store_data,
	output rv32_pkg::word_t target,
	output logic redirect
);

	rv32_pkg::word_t src_a;
	rv32_pkg::word_t src_b;
	rv32_pkg::word_t op_a;
	rv32_pkg::word_t op_b;
	rv32_pkg::word_t jalr_sum;
	logic taken;

	function automatic rv32_pkg::word_t select_source(
		input logic [1:0] sel,
		input rv32_pkg::word_t reg_val,
		input rv32_pkg::word_t mem_val,
		input rv32_pkg::word_t wb_val
	);
		case (sel)
			2'd1: return mem_val;
			2'd2: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign src_a = select_source(fwd_sel_a, rs1_data, mem_fwd, wb_fwd);
	assign src_b = select_source(fwd_sel_b, rs2_data, mem_fwd, wb_fwd);

	assign op_a = (ctrl.op_a_sel == rv32_pkg::op_a_pc) ? pc : src_a;
	assign op_b = (ctrl.op_b_sel == rv32_pkg::op_b_imm) ? ctrl.imm : src_b;

	// stores carry the forwarded rs2
	assign store_data = src_b;

	always_comb begin
		case (ctrl.alu_op)
			rv32_pkg::alu_sub: alu_out = op_a - op_b;
			rv32_pkg::alu_sll: alu_out = op_a << op_b[4:0];
			rv32_pkg::alu_slt: alu_out = rv32_pkg::word_t'($signed(op_a) < $signed(op_b));
			rv32_pkg::alu_sltu: alu_out = rv32_pkg::word_t'(op_a < op_b);
			rv32_pkg::alu_xor: alu_out = op_a ^ op_b;
			rv32_pkg::alu_srl: alu_out = op_a >> op_b[4:0];
			rv32_pkg::alu_sra: alu_out = rv32_pkg::word_t'($signed(op_a) >>> op_b[4:0]);
			rv32_pkg::alu_or: alu_out = op_a | op_b;
			rv32_pkg::alu_and: alu_out = op_a & op_b;
			default: alu_out = op_a + op_b;
		endcase
	end

	// branch compare on register operands, never the immediate
	always_comb begin
		case (ctrl.cmp_op)
			rv32_pkg::cmp_ne: taken = src_a != src_b;
			rv32_pkg::cmp_lt: taken = $signed(src_a) < $signed(src_b);
			rv32_pkg::cmp_ge: taken = $signed(src_a) >= $signed(src_b);
			default: taken = src_a == src_b;
		endcase
	end

	always_comb begin
		case (ctrl.jump_kind)
			rv32_pkg::jump_branch: redirect = taken;
			rv32_pkg::jump_jal: redirect = 1'b1;
			rv32_pkg::jump_jalr: redirect = 1'b1;
			default: redirect = 1'b0;
		endcase
	end

	assign jalr_sum = src_a + ctrl.imm;

	// jalr drops bit 0 of the sum
	assign target = (ctrl.jump_kind == rv32_pkg::jump_jalr) ?
		{jalr_sum[31:1], 1'b0} : pc + ctrl.imm;

endmodule

`default_nettype wire

// File: src/pipeline_core.sv
`default_nettype none
`include "cpu_params.svh"

module pipeline_core (
	input logic clk,
	input logic arst_n,
	output rv32_pkg::word_t instr_addr,
	output logic instr_load,
	input logic instr_resp,
	input rv32_pkg::word_t instr_rdata,
	output logic data_read,
	output logic data_write,
	output rv32_pkg::word_t data_addr,
	output rv32_pkg::word_t data_wdata,
	output rv32_pkg::byte_mask_t data_wmask,
	output logic data_load,
	input logic data_resp,
	input rv32_pkg::word_t data_rdata
);

	// fetch
	rv32_pkg::word_t pc;

	// decode
	rv32_pkg::word_t id_pc;
	rv32_pkg::ctrl_word_t id_ctrl;
	rv32_pkg::ctrl_word_t dec_ctrl;
	rv32_pkg::word_t rf_rs1_data;
	rv32_pkg::word_t rf_rs2_data;

	// execute
	rv32_pkg::word_t ex_pc;
	rv32_pkg::ctrl_word_t ex_ctrl;
	rv32_pkg::word_t ex_rs1_data;
	rv32_pkg::word_t ex_rs2_data;
	rv32_pkg::word_t ex_alu_out;
	rv32_pkg::word_t ex_store_data;
	rv32_pkg::word_t ex_target;
	logic redirect;

	// memory
	rv32_pkg::ctrl_word_t mem_ctrl;
	rv32_pkg::word_t mem_pc;
	rv32_pkg::word_t mem_alu_out;
	rv32_pkg::word_t mem_store_data;
	rv32_pkg::word_t mem_result;

	// writeback
	rv32_pkg::ctrl_word_t wb_ctrl;
	rv32_pkg::word_t wb_result;
	rv32_pkg::word_t wb_rdata;
	rv32_pkg::word_t wb_value;

	logic [1:0] fwd_sel_a;
	logic [1:0] fwd_sel_b;
	logic pc_load;
	logic id_load;
	logic ex_load;
	logic mem_load;
	logic wb_load;
	logic id_flush;
	logic ex_flush;

	control_decoder control_decoder_i (
		.instr(instr_rdata),
		.ctrl(dec_ctrl)
	);

	regfile regfile_i (
		.clk,
		.arst_n,
		.rs1(id_ctrl.rs1),
		.rs2(id_ctrl.rs2),
		.rd(wb_ctrl.rd),
		.wdata(wb_value),
		.we(wb_ctrl.load_regfile),
		.rs1_data(rf_rs1_data),
		.rs2_data(rf_rs2_data)
	);

	hazard_unit hazard_unit_i (
		.ex_ctrl,
		.mem_ctrl,
		.wb_ctrl,
		.id_ctrl,
		.instr_resp,
		.data_resp,
		.redirect,
		.fwd_sel_a,
		.fwd_sel_b,
		.pc_load,
		.id_load,
		.ex_load,
		.mem_load,
		.wb_load,
		.id_flush,
		.ex_flush
	);

	execute_unit execute_unit_i (
		.ctrl(ex_ctrl),
		.pc(ex_pc),
		.rs1_data(ex_rs1_data),
		.rs2_data(ex_rs2_data),
		.mem_fwd(mem_result),
		.wb_fwd(wb_value),
		.fwd_sel_a,
		.fwd_sel_b,
		.alu_out(ex_alu_out),
		.store_data(ex_store_data),
		.target(ex_target),
		.redirect
	);

	// control words and pc
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= `CPU_RESET_PC;
			id_ctrl <= '0;
			ex_ctrl <= '0;
			mem_ctrl <= '0;
			wb_ctrl <= '0;
		end else begin
			if (pc_load) begin
				pc <= redirect ? ex_target : pc + 32'd4;
			end
			if (id_load) begin
				if (id_flush) begin
					id_ctrl <= '0;
				end else begin
					id_ctrl <= dec_ctrl;
				end
			end
			if (ex_load) begin
				if (ex_flush) begin
					ex_ctrl <= '0;
				end else begin
					ex_ctrl <= id_ctrl;
				end
			end
			if (mem_load) begin
				mem_ctrl <= ex_ctrl;
			end
			if (wb_load) begin
				wb_ctrl <= mem_ctrl;
			end
		end
	end

	// stage payloads
	always_ff @(posedge clk) begin
		if (id_load) begin
			id_pc <= pc;
		end
		if (ex_load) begin
			ex_pc <= id_pc;
			ex_rs1_data <= rf_rs1_data;
			ex_rs2_data <= rf_rs2_data;
		end
		if (mem_load) begin
			mem_pc <= ex_pc;
			mem_alu_out <= ex_alu_out;
			mem_store_data <= ex_store_data;
		end
		if (wb_load) begin
			wb_result <= mem_result;
			// proxy may be refilled while this load sits in writeback
			wb_rdata <= data_rdata;
		end
	end

	// link value or alu result, also the memory-stage forward
	assign mem_result = (mem_ctrl.wb_sel == rv32_pkg::wb_pc4) ? mem_pc + 32'd4 : mem_alu_out;
	assign wb_value = (wb_ctrl.wb_sel == rv32_pkg::wb_mem) ? wb_rdata : wb_result;

	assign instr_addr = pc;
	assign instr_load = id_load;

	assign data_read = mem_ctrl.mem_read;
	assign data_write = mem_ctrl.mem_write;
	assign data_addr = mem_alu_out;
	assign data_wdata = mem_store_data;
	assign data_wmask = {4{mem_ctrl.mem_write}};
	assign data_load = wb_load;

	// jump targets come from register values, so misalignment is possible
	a_pc_aligned: assert property (
		@(posedge clk) disable iff (!arst_n)
		pc[1:0] == 2'b00
	);

endmodule

`default_nettype wire

// File: src/pipeline_cpu.sv
`default_nettype none

module pipeline_cpu (
	input logic clk,
	input logic arst_n,

	// instruction port
	output logic read_a,
	output logic write_a,
	output rv32_pkg::byte_mask_t wmask_a,
	output rv32_pkg::word_t address_a,
	output rv32_pkg::word_t wdata_a,
	input logic resp_a,
	input rv32_pkg::word_t rdata_a,

	// data port
	output logic read_b,
	output logic write_b,
	output rv32_pkg::byte_mask_t wmask_b,
	output rv32_pkg::word_t address_b,
	output rv32_pkg::word_t wdata_b,
	input logic resp_b,
	input rv32_pkg::word_t rdata_b
);

	mem_port_if imem_bus ();
	mem_port_if dmem_bus ();

	rv32_pkg::word_t instr_addr;
	logic instr_load;
	logic instr_resp;
	rv32_pkg::word_t instr_rdata;
	logic data_read;
	logic data_write;
	rv32_pkg::word_t data_addr;
	rv32_pkg::word_t data_wdata;
	rv32_pkg::byte_mask_t data_wmask;
	logic data_load;
	logic data_resp;
	rv32_pkg::word_t data_rdata;

	assign read_a = imem_bus.read;
	assign write_a = imem_bus.write;
	assign wmask_a = imem_bus.wmask;
	assign address_a = imem_bus.address;
	assign wdata_a = imem_bus.wdata;
	assign imem_bus.resp = resp_a;
	assign imem_bus.rdata = rdata_a;

	assign read_b = dmem_bus.read;
	assign write_b = dmem_bus.write;
	assign wmask_b = dmem_bus.wmask;
	assign address_b = dmem_bus.address;
	assign wdata_b = dmem_bus.wdata;
	assign dmem_bus.resp = resp_b;
	assign dmem_bus.rdata = rdata_b;

	// fetch always wants a word, never writes
	mem_access_proxy icache_proxy_i (
		.clk,
		.arst_n,
		.stage_read(1'b1),
		.stage_write(1'b0),
		.stage_addr(instr_addr),
		.stage_wdata('0),
		.stage_wmask('0),
		.pipe_load(instr_load),
		.stage_resp(instr_resp),
		.stage_rdata(instr_rdata),
		.mem(imem_bus.memory)
	);

	mem_access_proxy dcache_proxy_i (
		.clk,
		.arst_n,
		.stage_read(data_read),
		.stage_write(data_write),
		.stage_addr(data_addr),
		.stage_wdata(data_wdata),
		.stage_wmask(data_wmask),
		.pipe_load(data_load),
		.stage_resp(data_resp),
		.stage_rdata(data_rdata),
		.mem(dmem_bus.memory)
	);

	pipeline_core pipeline_core_i (
		.clk,
		.arst_n,
		.instr_addr,
		.instr_load,
		.instr_resp,
		.instr_rdata,
		.data_read,
		.data_write,
		.data_addr,
		.data_wdata,
		.data_wmask,
		.data_load,
		.data_resp,
		.data_rdata
	);

endmodule

`default_nettype wire

// File: verification/tb_memory_model.sv
`default_nettype none

module tb_memory_model #(
	parameter logic [31:0] seed = 32'hc06c
) (
	input logic clk,
	input logic read,
	input logic write,
	input rv32_pkg::byte_mask_t wmask,
	input rv32_pkg::word_t address,
	input rv32_pkg::word_t wdata,
	output logic resp,
	output rv32_pkg::word_t rdata
);

	// 1 KiB of word-addressed storage
	rv32_pkg::word_t mem [256];
	rv32_pkg::word_t observed [$];

	logic [31:0] rng_state = seed;
	logic busy = 1'b0;
	logic [1:0] remaining = 2'd0;
	logic resp_q = 1'b0;
	rv32_pkg::word_t rdata_q = '0;

	assign resp = resp_q;
	assign rdata = rdata_q;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// requests only change on the rising edge
	always @(negedge clk) begin
		if (resp_q) begin
			resp_q = 1'b0;
		end else if (read || write) begin
			if (!busy) begin
				rng_state = xorshift(rng_state);
				// 0 to 3 extra cycles
				remaining = rng_state[1:0];
				busy = 1'b1;
			end
			if (remaining == 2'd0) begin
				busy = 1'b0;
				resp_q = 1'b1;
				if (write) begin
					// byte lanes follow wmask
					for (int b = 0; b < 4; b++) begin
						if (wmask[b]) begin
							mem[address[9:2]][8*b +: 8] = wdata[8*b +: 8];
						end
					end
					observed.push_back(wdata);
				end else begin
					rdata_q = mem[address[9:2]];
				end
			end else begin
				remaining = remaining - 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verification/tb_pipeline_cpu.sv
`default_nettype none
`include "cpu_params.svh"

module tb_pipeline_cpu;

	localparam int timeout_cycles = 2000;
	localparam int drain_cycles = 50;
	localparam rv32_pkg::word_t marker_addr = 32'h0000_0300;
	localparam rv32_pkg::word_t load_addr = 32'h0000_0100;
	localparam rv32_pkg::word_t nop_word = 32'h0000_0013;
	localparam logic [6:0] opc_op_imm = 7'b0010011;

	logic clk;
	logic arst_n;
	logic read_a;
	logic write_a;
	rv32_pkg::byte_mask_t wmask_a;
	rv32_pkg::word_t address_a;
	rv32_pkg::word_t wdata_a;
	logic resp_a;
	rv32_pkg::word_t rdata_a;
	logic read_b;
	logic write_b;
	rv32_pkg::byte_mask_t wmask_b;
	rv32_pkg::word_t address_b;
	rv32_pkg::word_t wdata_b;
	logic resp_b;
	rv32_pkg::word_t rdata_b;

	rv32_pkg::word_t program_words [$];
	rv32_pkg::word_t exp_addr [8];
	rv32_pkg::word_t exp_data [8];
	int n_exp = 0;
	int store_idx = 0;
	int assert_errors = 0;
	int check_errors = 0;
	int timeouts = 0;
	logic store_seen;

	pipeline_cpu pipeline_cpu_i (
		.clk,
		.arst_n,
		.read_a,
		.write_a,
		.wmask_a,
		.address_a,
		.wdata_a,
		.resp_a,
		.rdata_a,
		.read_b,
		.write_b,
		.wmask_b,
		.address_b,
		.wdata_b,
		.resp_b,
		.rdata_b
	);

	tb_memory_model #(.seed(32'hc06c)) imem_model_i (
		.clk,
		.read(read_a),
		.write(write_a),
		.wmask(wmask_a),
		.address(address_a),
		.wdata(wdata_a),
		.resp(resp_a),
		.rdata(rdata_a)
	);

	tb_memory_model #(.seed(32'hc06c)) dmem_model_i (
		.clk,
		.read(read_b),
		.write(write_b),
		.wmask(wmask_b),
		.address(address_b),
		.wdata(wdata_b),
		.resp(resp_b),
		.rdata(rdata_b)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	function automatic rv32_pkg::word_t r_type(input logic [6:0] f7, input rv32_pkg::reg_idx_t rs2,
		input rv32_pkg::reg_idx_t rs1, input logic [2:0] f3, input rv32_pkg::reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic rv32_pkg::word_t i_type(input logic [11:0] imm, input rv32_pkg::reg_idx_t rs1,
		input logic [2:0] f3, input rv32_pkg::reg_idx_t rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	// word store only
	function automatic rv32_pkg::word_t s_type(input logic [11:0] imm, input rv32_pkg::reg_idx_t rs2,
		input rv32_pkg::reg_idx_t rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic rv32_pkg::word_t b_type(input logic [12:0] imm, input rv32_pkg::reg_idx_t rs2,
		input rv32_pkg::reg_idx_t rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic rv32_pkg::word_t j_type(input logic [20:0] imm, input rv32_pkg::reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// data memory background pattern over every address bit
	function automatic rv32_pkg::word_t fill_word(input rv32_pkg::word_t addr);
		return addr ^ {addr[15:0], addr[31:16]} ^ 32'h6b8f_1c35;
	endfunction

	task automatic expect_store(input rv32_pkg::word_t addr, input rv32_pkg::reg_idx_t src,
		input rv32_pkg::word_t value);
		program_words.push_back(s_type(addr[11:0], src, 5'd0));
		exp_addr[n_exp[2:0]] = addr;
		exp_data[n_exp[2:0]] = value;
		n_exp++;
	endtask

	task automatic assemble_program();
		rv32_pkg::word_t r1;
		rv32_pkg::word_t r2;
		rv32_pkg::word_t r3;
		rv32_pkg::word_t r4;
		rv32_pkg::word_t r5;
		rv32_pkg::word_t r6;
		rv32_pkg::word_t link;
		r1 = 32'd5;
		r2 = r1 + 32'd7;
		r3 = r2 + r1;
		r4 = r3 - r2;
		r5 = r4 ^ r3;
		r6 = ($signed(r4) < $signed(r5)) ? 32'd1 : 32'd0;
		// back to back dependent chain
		program_words.push_back(i_type(12'd5, 5'd0, 3'b000, 5'd1, opc_op_imm));
		program_words.push_back(i_type(12'd7, 5'd1, 3'b000, 5'd2, opc_op_imm));
		program_words.push_back(r_type(7'b0000000, 5'd1, 5'd2, 3'b000, 5'd3));
		program_words.push_back(r_type(7'b0100000, 5'd2, 5'd3, 3'b000, 5'd4));
		program_words.push_back(r_type(7'b0000000, 5'd3, 5'd4, 3'b100, 5'd5));
		program_words.push_back(r_type(7'b0000000, 5'd5, 5'd4, 3'b010, 5'd6));
		expect_store(32'h200, 5'd2, r2);
		expect_store(32'h204, 5'd3, r3);
		expect_store(32'h208, 5'd4, r4);
		expect_store(32'h20c, 5'd5, r5);
		expect_store(32'h210, 5'd6, r6);
		// load then immediate use
		program_words.push_back(i_type(load_addr[11:0], 5'd0, 3'b010, 5'd7, 7'b0000011));
		program_words.push_back(r_type(7'b0000000, 5'd1, 5'd7, 3'b000, 5'd8));
		expect_store(32'h214, 5'd8, fill_word(load_addr) + r1);
		// x1 equals x4, so beq is taken and bne is not
		program_words.push_back(b_type(13'd8, 5'd4, 5'd1, 3'b000));
		program_words.push_back(s_type(marker_addr[11:0], 5'd2, 5'd0));
		program_words.push_back(b_type(13'd8, 5'd4, 5'd1, 3'b001));
		expect_store(32'h218, 5'd2, r2);
		link = rv32_pkg::word_t'(program_words.size() * 4) + 32'd4;
		program_words.push_back(j_type(21'd8, 5'd9));
		program_words.push_back(s_type(marker_addr[11:0], 5'd2, 5'd0));
		expect_store(32'h21c, 5'd9, link);
		// park on a self jump
		program_words.push_back(j_type(21'd0, 5'd0));
	endtask

	task automatic load_memories();
		for (int i = 0; i < 256; i++) begin
			if (i < program_words.size()) begin
				imem_model_i.mem[i[7:0]] = program_words[i];
			end else begin
				imem_model_i.mem[i[7:0]] = nop_word;
			end
			dmem_model_i.mem[i[7:0]] = fill_word(rv32_pkg::word_t'(i) << 2);
		end
	endtask

	assign store_seen = write_b && resp_b;

	always @(posedge clk) begin
		if (store_seen) begin
			store_idx <= store_idx + 1;
		end
	end

	a_reset_ports: assert property (@(posedge clk)
		!arst_n |-> (!read_b && !write_b && read_a && address_a == `CPU_RESET_PC))
	else begin
		assert_errors++;
		$display("Error at %0t: port state wrong while in reset", $time);
	end

	a_first_fetch: assert property (@(posedge clk)
		$rose(arst_n) |-> (read_a && address_a == `CPU_RESET_PC && !read_b && !write_b))
	else begin
		assert_errors++;
		$display("Error at %0t: port state wrong just after reset", $time);
	end

	a_store_order: assert property (@(posedge clk) disable iff (!arst_n)
		store_seen |-> (store_idx < n_exp && address_b == exp_addr[store_idx[2:0]] &&
			wdata_b == exp_data[store_idx[2:0]]))
	else begin
		assert_errors++;
		$display("Error at %0t: store address or data differs from expected", $time);
	end

	a_store_mask: assert property (@(posedge clk) disable iff (!arst_n)
		store_seen |-> wmask_b == 4'hf)
	else begin
		assert_errors++;
		$display("Error at %0t: store wmask is not all ones", $time);
	end

	a_marker_untouched: assert property (@(posedge clk) disable iff (!arst_n)
		store_seen |-> address_b != marker_addr)
	else begin
		assert_errors++;
		$display("Error at %0t: skipped store reached the marker address", $time);
	end

	// the fetch port is read only, its write channel stays idle
	a_fetch_no_write: assert property (@(posedge clk)
		!write_a && wmask_a == '0 && wdata_a == '0)
	else begin
		assert_errors++;
		$display("Error at %0t: instruction port drove write, wmask or wdata", $time);
	end

	initial begin
		int cycles;
		arst_n = 1'b0;
		assemble_program();
		load_memories();
		repeat (3) @(negedge clk);
		arst_n = 1'b1;
		cycles = 0;
		while (dmem_model_i.observed.size() < n_exp && cycles < timeout_cycles) begin
			@(negedge clk);
			cycles++;
		end
		if (dmem_model_i.observed.size() < n_exp) begin
			timeouts++;
			$display("Timeout: %0d of %0d stores seen after %0d cycles",
				dmem_model_i.observed.size(), n_exp, cycles);
		end
		// keep the self jump spinning so a late stray store would show up
		repeat (drain_cycles) @(negedge clk);
		assert (dmem_model_i.observed.size() == n_exp)
		else begin
			check_errors++;
			$display("Error at %0t: %0d stores observed, %0d expected", $time,
				dmem_model_i.observed.size(), n_exp);
		end
		for (int k = 0; k < n_exp && k < dmem_model_i.observed.size(); k++) begin
			assert (dmem_model_i.observed[k] == exp_data[k[2:0]])
			else begin
				check_errors++;
				$display("Error at %0t: store %0d wrote %h, expected %h", $time, k,
					dmem_model_i.observed[k], exp_data[k[2:0]]);
			end
		end
		$display("Summary: %0d stores, %0d assertion errors, %0d check errors, %0d timeouts",
			store_idx, assert_errors, check_errors, timeouts);
		if (assert_errors == 0 && check_errors == 0 && timeouts == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+src
src/rv32_pkg.sv
src/mem_port_if.sv
src/mem_access_proxy.sv
src/control_decoder.sv
src/regfile.sv
src/hazard_unit.sv
src/execute_unit.sv
src/pipeline_core.sv
src/pipeline_cpu.sv
verification/tb_memory_model.sv
verification/tb_pipeline_cpu.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --assert
TOP := tb_pipeline_cpu
FILELIST := files.f
OBJ_DIR := obj_dir
BIN := $(OBJ_DIR)/V$(TOP)
LOG := sim.log
SOURCES := $(shell grep -v '^+' $(FILELIST)) src/cpu_params.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "run failed"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
